//--- sim.f
+incdir+include
src/gps_sample_pkg.sv
src/gps_corr_pkg.sv
src/baseband_if.sv
src/corr_dump_if.sv
src/carrier_mixer.sv
src/correlator_bank.sv
src/power_detector.sv
src/gps_channel.sv
sim/power_checker.sv
sim/tb_gps_channel.sv

//--- Bender.yml
package:
  name: gps_channel

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/gps_sample_pkg.sv
      - src/gps_corr_pkg.sv
      - src/baseband_if.sv
      - src/corr_dump_if.sv
      - src/carrier_mixer.sv
      - src/correlator_bank.sv
      - src/power_detector.sv
      - src/gps_channel.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/power_checker.sv
      - sim/tb_gps_channel.sv

//--- sim/tb_gps_channel.sv
`timescale 1ns/1ps
`include "gps_corr_consts.svh"

module tb_gps_channel;

   localparam int NUM_ROWS     = 10;
   localparam int RESET_CYCLES = 4;
   localparam int DRIVE_DELAY  = 2;
   localparam int DISCARDS     = 1;

   typedef enum logic [1:0] {SMP_CONST, SMP_ALT, SMP_RANDOM} sample_kind_e;
   typedef enum logic [1:0] {CODE_ONES, CODE_ALT, CODE_RANDOM} code_kind_e;

   typedef struct packed {
      gps_sample_pkg::phase_t  doppler;
      sample_kind_e            smp_kind;
      gps_sample_pkg::sample_t value;
      code_kind_e              code_kind;
      int                      gap;
      int                      ack_delay;
   } row_t;

   logic                    clk;
   logic                    i_reset;
   logic                    i_sample_valid;
   gps_sample_pkg::sample_t i_sample;
   logic                    i_ca_bit;
   gps_sample_pkg::phase_t  i_doppler_inc;
   gps_corr_pkg::power_t    o_power_early;
   gps_corr_pkg::power_t    o_power_prompt;
   gps_corr_pkg::power_t    o_power_late;
   logic                    o_power_req;
   logic                    i_power_ack;
   logic                    o_overrun;

   row_t   rows [NUM_ROWS];
   integer seed;
   int     ack_delay_now;
   int     timeout_limit;
   int     cycle_count;
   int     local_fails;
   int     pass_count;
   int     fail_count;
   int     error_count;
   int     overrun_count;

   gps_channel u_gps_channel (
      .clk            (clk),
      .i_reset        (i_reset),
      .i_sample_valid (i_sample_valid),
      .i_sample       (i_sample),
      .i_ca_bit       (i_ca_bit),
      .i_doppler_inc  (i_doppler_inc),
      .o_power_early  (o_power_early),
      .o_power_prompt (o_power_prompt),
      .o_power_late   (o_power_late),
      .o_power_req    (o_power_req),
      .i_power_ack    (i_power_ack),
      .o_overrun      (o_overrun)
   );

   power_checker u_power_checker (
      .clk             (clk),
      .i_reset         (i_reset),
      .i_sample_valid  (i_sample_valid),
      .i_sample        (i_sample),
      .i_ca_bit        (i_ca_bit),
      .i_doppler_inc   (i_doppler_inc),
      .i_power_early   (o_power_early),
      .i_power_prompt  (o_power_prompt),
      .i_power_late    (o_power_late),
      .i_power_req     (o_power_req),
      .i_power_ack     (i_power_ack),
      .i_overrun       (o_overrun),
      .o_pass_count    (pass_count),
      .o_fail_count    (fail_count),
      .o_error_count   (error_count),
      .o_overrun_count (overrun_count)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Doppler, samples, value, code, gap, ack delay.
   // Row 7 holds req long enough that the dump of row 8 is dropped.
   task automatic load_table();
      rows[0] = '{16'h0000, SMP_CONST, 4'sd3, CODE_ONES, 0, 3};
      rows[1] = '{16'h0000, SMP_CONST, 4'sd3, CODE_ONES, 2, 0};
      rows[2] = '{16'h0000, SMP_RANDOM, 4'sd0, CODE_ALT, 0, 1};
      rows[3] = '{16'h0000, SMP_RANDOM, 4'sd0, CODE_RANDOM, 1, 5};
      rows[4] = '{16'h0400, SMP_CONST, -4'sd5, CODE_ONES, 0, 2};
      rows[5] = '{16'h1234, SMP_RANDOM, 4'sd0, CODE_RANDOM, 0, 4};
      rows[6] = '{16'hf000, SMP_ALT, 4'sd7, CODE_ALT, 0, 0};
      rows[7] = '{16'h0800, SMP_RANDOM, 4'sd0, CODE_ONES, 0, 90};
      rows[8] = '{16'h0800, SMP_CONST, 4'sd6, CODE_ONES, 0, 2};
      rows[9] = '{16'h0300, SMP_RANDOM, 4'sd0, CODE_RANDOM, 0, 2};
   endtask

   function automatic int run_length();
      int total;
      int r;
      total = 0;
      for (r = 0; r < NUM_ROWS; r++) begin
         total += `SAMPLES_PER_DUMP * (rows[r].gap + 1) + rows[r].ack_delay + 40;
      end
      return total;
   endfunction

   task automatic feed_row(input row_t row);
      int n;
      int g;
      int rnd;
      for (n = 0; n < `SAMPLES_PER_DUMP; n++) begin
         i_sample_valid = 1'b1;
         i_doppler_inc  = row.doppler;
         rnd            = $random(seed);
         case (row.smp_kind)
            SMP_CONST: i_sample = row.value;
            SMP_ALT:   i_sample = n[0] ? -row.value : row.value;
            default:   i_sample = rnd[3:0];
         endcase
         case (row.code_kind)
            CODE_ONES: i_ca_bit = 1'b1;
            CODE_ALT:  i_ca_bit = n[0];
            default:   i_ca_bit = rnd[7];
         endcase
         @(posedge clk);
         #DRIVE_DELAY;
         i_sample_valid = 1'b0;
         for (g = 0; g < row.gap; g++) begin
            @(posedge clk);
            #DRIVE_DELAY;
         end
      end
   endtask

   // The last row's req, then its full handshake.
   task automatic wait_last_handshake();
      @(posedge clk);
      #DRIVE_DELAY;
      while (o_power_req !== 1'b1) begin
         @(posedge clk);
         #DRIVE_DELAY;
      end
      while (o_power_req !== 1'b0 || i_power_ack !== 1'b0) begin
         @(posedge clk);
         #DRIVE_DELAY;
      end
      repeat (2) @(posedge clk);
   endtask

   initial begin : ack_driver
      int delay;
      i_power_ack = 1'b0;
      wait (i_reset === 1'b0);
      forever begin
         @(posedge clk);
         #DRIVE_DELAY;
         if (o_power_req === 1'b1) begin
            delay = ack_delay_now;
            repeat (delay) begin
               @(posedge clk);
               #DRIVE_DELAY;
            end
            i_power_ack = 1'b1;
            while (o_power_req === 1'b1) begin
               @(posedge clk);
               #DRIVE_DELAY;
            end
            i_power_ack = 1'b0;
         end
      end
   end

   initial begin : watchdog
      cycle_count = 0;
      @(posedge clk);
      while (cycle_count < timeout_limit) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout: the run did not finish within %0d cycles", timeout_limit);
      $display("SIMULATION FAILED");
      $finish;
   end

   initial begin : stimulus
      int r;
      i_reset        = 1'b1;
      i_sample_valid = 1'b0;
      i_sample       = '0;
      i_ca_bit       = 1'b0;
      i_doppler_inc  = '0;
      seed           = 32'hfd64f800;
      ack_delay_now  = 0;
      local_fails    = 0;
      load_table();
      timeout_limit = run_length();
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      i_reset = 1'b0;
      for (r = 0; r < NUM_ROWS; r++) begin
         feed_row(rows[r]);
         ack_delay_now = rows[r].ack_delay;
      end
      wait_last_handshake();
      if (overrun_count != DISCARDS) begin
         $display("expected %0d dropped dump during the slow ack, saw %0d",
                  DISCARDS, overrun_count);
         local_fails++;
      end
      if (pass_count + fail_count != NUM_ROWS - DISCARDS) begin
         $display("expected %0d presented results, saw %0d",
                  NUM_ROWS - DISCARDS, pass_count + fail_count);
         local_fails++;
      end
      $display("tests passed %0d, tests failed %0d, errors %0d, overruns %0d",
               pass_count, fail_count, error_count, overrun_count);
      if (fail_count == 0 && error_count == 0 && local_fails == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

//--- sim/power_checker.sv
`timescale 1ns/1ps
`include "gps_corr_consts.svh"

module power_checker (
   input  logic                    clk,
   input  logic                    i_reset,
   input  logic                    i_sample_valid,
   input  gps_sample_pkg::sample_t i_sample,
   input  logic                    i_ca_bit,
   input  gps_sample_pkg::phase_t  i_doppler_inc,
   input  gps_corr_pkg::power_t    i_power_early,
   input  gps_corr_pkg::power_t    i_power_prompt,
   input  gps_corr_pkg::power_t    i_power_late,
   input  logic                    i_power_req,
   input  logic                    i_power_ack,
   input  logic                    i_overrun,
   output int                      o_pass_count,
   output int                      o_fail_count,
   output int                      o_error_count,
   output int                      o_overrun_count
);

   // Cycles from the last valid sample to the dump and to req.
   localparam int DUMP_DELAY  = 2;
   localparam int REQ_LATENCY = 12;
   localparam int LINE_LEN    = 2 * `CODE_SPACING;

   typedef enum {M_IDLE, M_BUSY, M_HOLD, M_RELEASE} model_state_e;

   model_state_e m_state;
   int           cycle_n;
   int           phase;
   int           sample_n;
   int           dump_n;
   int           test_n;
   logic         hist [LINE_LEN];
   int           acc_i [3];
   int           acc_q [3];
   int           snap [3];
   int           expect_pwr [3];
   logic         tap_bad [3];
   logic         dump_pending;
   int           dump_edge;
   int           snap_req_edge;
   int           req_edge;
   int           ovr_edge;
   logic         req_bad;

   // Octant carrier levels.
   function automatic int cos_level(input int octant);
      case (octant)
         0, 7:    return 2;
         1, 6:    return 1;
         2, 5:    return -1;
         default: return -2;
      endcase
   endfunction

   function automatic int sin_level(input int octant);
      case (octant)
         0, 3:    return 1;
         1, 2:    return 2;
         4, 7:    return -1;
         default: return -2;
      endcase
   endfunction

   task automatic reset_model();
      int t;
      m_state      = M_IDLE;
      cycle_n      = 0;
      phase        = 0;
      sample_n     = 0;
      dump_n       = 0;
      test_n       = 0;
      dump_pending = 1'b0;
      dump_edge    = -1;
      req_edge     = -1;
      ovr_edge     = -1;
      req_bad      = 1'b0;
      for (t = 0; t < 3; t++) begin
         acc_i[t]      = 0;
         acc_q[t]      = 0;
         expect_pwr[t] = 0;
         tap_bad[t]    = 1'b0;
      end
      for (t = 0; t < LINE_LEN; t++) begin
         hist[t] = 1'b0;
      end
      o_pass_count    = 0;
      o_fail_count    = 0;
      o_error_count   = 0;
      o_overrun_count = 0;
   endtask

   // One valid sample through carrier, code taps and accumulators.
   task automatic take_sample();
      int   smp;
      int   oct;
      int   prod_i;
      int   prod_q;
      int   t;
      logic chip [3];
      smp     = int'(i_sample);
      oct     = phase >> (`PHASE_WIDTH - 3);
      prod_i  = smp * cos_level(oct);
      prod_q  = smp * sin_level(oct);
      chip[0] = i_ca_bit;
      chip[1] = hist[`CODE_SPACING-1];
      chip[2] = hist[LINE_LEN-1];
      for (t = 0; t < 3; t++) begin
         acc_i[t] += chip[t] ? prod_i : -prod_i;
         acc_q[t] += chip[t] ? prod_q : -prod_q;
      end
      for (t = LINE_LEN - 1; t > 0; t--) begin
         hist[t] = hist[t-1];
      end
      hist[0]  = i_ca_bit;
      phase    = (phase + int'(i_doppler_inc)) & 32'h0000_ffff;
      sample_n = sample_n + 1;
      if (sample_n == `SAMPLES_PER_DUMP) begin
         for (t = 0; t < 3; t++) begin
            snap[t]  = acc_i[t] * acc_i[t] + acc_q[t] * acc_q[t];
            acc_i[t] = 0;
            acc_q[t] = 0;
         end
         sample_n      = 0;
         dump_pending  = 1'b1;
         dump_edge     = cycle_n + DUMP_DELAY;
         snap_req_edge = cycle_n + REQ_LATENCY;
      end
   endtask

   task automatic compare_power(input int tap, input gps_corr_pkg::power_t actual);
      string name;
      name = (tap == 0) ? "o_power_early" : (tap == 1) ? "o_power_prompt" : "o_power_late";
      if (actual !== gps_corr_pkg::power_t'(expect_pwr[tap]) && !tap_bad[tap]) begin
         $display("error: %s expected 0x%06h, got 0x%06h in test %0d", name,
                  gps_corr_pkg::power_t'(expect_pwr[tap]), actual, test_n);
         tap_bad[tap]  = 1'b1;
         o_error_count = o_error_count + 1;
      end
   endtask

   task automatic finish_test();
      if (tap_bad[0] || tap_bad[1] || tap_bad[2]) begin
         o_fail_count = o_fail_count + 1;
         $display("test %0d (dump %0d): fail", test_n, dump_n);
      end else begin
         o_pass_count = o_pass_count + 1;
         $display("test %0d (dump %0d): pass, early 0x%06h prompt 0x%06h late 0x%06h",
                  test_n, dump_n, i_power_early, i_power_prompt, i_power_late);
      end
   endtask

   always @(posedge clk) begin : model_step
      model_state_e cur;
      if (i_reset) begin
         reset_model();
      end else begin
         cycle_n = cycle_n + 1;
         if (m_state == M_BUSY && cycle_n == req_edge) begin
            m_state = M_HOLD;
         end
         cur = m_state;
         if (i_power_req !== (cur == M_HOLD)) begin
            if (!req_bad) begin
               $display("error: o_power_req expected 0x%0h, got 0x%0h at cycle %0d",
                        cur == M_HOLD, i_power_req, cycle_n);
               o_error_count = o_error_count + 1;
            end
            req_bad = 1'b1;
         end else begin
            req_bad = 1'b0;
         end
         if (i_overrun !== (cycle_n == ovr_edge)) begin
            $display("error: o_overrun expected 0x%0h, got 0x%0h at cycle %0d",
                     cycle_n == ovr_edge, i_overrun, cycle_n);
            o_error_count = o_error_count + 1;
         end
         // Powers must match for the whole hold.
         if (cur == M_HOLD) begin
            compare_power(0, i_power_early);
            compare_power(1, i_power_prompt);
            compare_power(2, i_power_late);
         end
         if (dump_pending && cycle_n == dump_edge) begin
            dump_pending = 1'b0;
            dump_n       = dump_n + 1;
            if (cur == M_IDLE) begin
               test_n     = test_n + 1;
               expect_pwr = snap;
               tap_bad    = '{1'b0, 1'b0, 1'b0};
               req_edge   = snap_req_edge;
               m_state    = M_BUSY;
            end else begin
               ovr_edge        = cycle_n + 1;
               o_overrun_count = o_overrun_count + 1;
               $display("dump %0d: discarded while results held, overrun expected", dump_n);
            end
         end
         if (cur == M_HOLD && i_power_ack) begin
            finish_test();
            m_state = M_RELEASE;
         end else if (cur == M_RELEASE && !i_power_ack) begin
            m_state = M_IDLE;
         end
         if (i_sample_valid) begin
            take_sample();
         end
      end
   end

endmodule

//--- src/gps_channel.sv
`timescale 1ns/1ps

module gps_channel (
   input  logic                    clk,
   input  logic                    i_reset,
   input  logic                    i_sample_valid,
   input  gps_sample_pkg::sample_t i_sample,
   input  logic                    i_ca_bit,
   input  gps_sample_pkg::phase_t  i_doppler_inc,
   output gps_corr_pkg::power_t    o_power_early,
   output gps_corr_pkg::power_t    o_power_prompt,
   output gps_corr_pkg::power_t    o_power_late,
   output logic                    o_power_req,
   input  logic                    i_power_ack,
   output logic                    o_overrun
);

   // Mixer to correlator.
   baseband_if bb_if ();

   // Correlator to power detector.
   corr_dump_if dump_if ();

   carrier_mixer u_carrier_mixer (
      .clk            (clk),
      .i_reset        (i_reset),
      .i_sample_valid (i_sample_valid),
      .i_sample       (i_sample),
      .i_ca_bit       (i_ca_bit),
      .i_doppler_inc  (i_doppler_inc),
      .bb             (bb_if.source)
   );

   correlator_bank u_correlator_bank (
      .clk     (clk),
      .i_reset (i_reset),
      .bb      (bb_if.sink),
      .dump    (dump_if.source)
   );

   power_detector u_power_detector (
      .clk            (clk),
      .i_reset        (i_reset),
      .dump           (dump_if.sink),
      .o_power_early  (o_power_early),
      .o_power_prompt (o_power_prompt),
      .o_power_late   (o_power_late),
      .o_power_req    (o_power_req),
      .i_power_ack    (i_power_ack),
      .o_overrun      (o_overrun)
   );

endmodule

//--- src/power_detector.sv
`timescale 1ns/1ps

module power_detector (
   input  logic                 clk,
   input  logic                 i_reset,
   corr_dump_if.sink            dump,
   output gps_corr_pkg::power_t o_power_early,
   output gps_corr_pkg::power_t o_power_prompt,
   output gps_corr_pkg::power_t o_power_late,
   output logic                 o_power_req,
   input  logic                 i_power_ack,
   output logic                 o_overrun
);

   gps_corr_pkg::power_state_e state;
   gps_corr_pkg::tap_e         tap_sel;
   logic                       sum_valid;
   gps_corr_pkg::mag_t         mag_i [3];
   gps_corr_pkg::mag_t         mag_q [3];
   gps_corr_pkg::mag_t         sel_i;
   gps_corr_pkg::mag_t         sel_q;
   gps_corr_pkg::power_t       sq_i;
   gps_corr_pkg::power_t       sq_q;
   gps_corr_pkg::power_t       sum;
   gps_corr_pkg::power_t       pwr [3];

   function automatic gps_corr_pkg::mag_t abs_acc(input gps_corr_pkg::acc_t a);
      return gps_corr_pkg::mag_t'(a < 0 ? -a : a);
   endfunction

   function automatic gps_corr_pkg::tap_e next_tap(input gps_corr_pkg::tap_e t);
      return (t == gps_corr_pkg::TAP_EARLY) ? gps_corr_pkg::TAP_PROMPT
                                             : gps_corr_pkg::TAP_LATE;
   endfunction

   // Magnitudes are taken only when the FSM is free.
   always_ff @(posedge clk) begin
      if (state == gps_corr_pkg::IDLE && dump.dump_valid) begin
         mag_i[gps_corr_pkg::TAP_EARLY]  <= abs_acc(dump.early_i);
         mag_q[gps_corr_pkg::TAP_EARLY]  <= abs_acc(dump.early_q);
         mag_i[gps_corr_pkg::TAP_PROMPT] <= abs_acc(dump.prompt_i);
         mag_q[gps_corr_pkg::TAP_PROMPT] <= abs_acc(dump.prompt_q);
         mag_i[gps_corr_pkg::TAP_LATE]   <= abs_acc(dump.late_i);
         mag_q[gps_corr_pkg::TAP_LATE]   <= abs_acc(dump.late_q);
      end
   end

   assign sel_i = mag_i[tap_sel];
   assign sel_q = mag_q[tap_sel];

   // Shared squarer pair, adder, then the tap's result register.
   always_ff @(posedge clk) begin
      if (state == gps_corr_pkg::SQUARE) begin
         sq_i <= gps_corr_pkg::power_t'(sel_i) * gps_corr_pkg::power_t'(sel_i);
         sq_q <= gps_corr_pkg::power_t'(sel_q) * gps_corr_pkg::power_t'(sel_q);
      end
      if (state == gps_corr_pkg::SUM && !sum_valid) begin
         sum <= sq_i + sq_q;
      end
      if (state == gps_corr_pkg::SUM && sum_valid) begin
         pwr[tap_sel] <= sum;
      end
   end

   // Each tap takes SQUARE plus two SUM cycles.
   always_ff @(posedge clk) begin
      if (i_reset) begin
         state     <= gps_corr_pkg::IDLE;
         tap_sel   <= gps_corr_pkg::TAP_EARLY;
         sum_valid <= 1'b0;
         o_overrun <= 1'b0;
      end else begin
         o_overrun <= dump.dump_valid && state != gps_corr_pkg::IDLE;
         case (state)
            gps_corr_pkg::IDLE: begin
               if (dump.dump_valid) begin
                  state   <= gps_corr_pkg::SQUARE;
                  tap_sel <= gps_corr_pkg::TAP_EARLY;
               end
            end
            gps_corr_pkg::SQUARE: begin
               state <= gps_corr_pkg::SUM;
            end
            gps_corr_pkg::SUM: begin
               sum_valid <= !sum_valid;
               if (sum_valid) begin
                  if (tap_sel == gps_corr_pkg::TAP_LATE) begin
                     state <= gps_corr_pkg::HOLD;
                  end else begin
                     tap_sel <= next_tap(tap_sel);
                     state   <= gps_corr_pkg::SQUARE;
                  end
               end
            end
            gps_corr_pkg::HOLD: begin
               if (i_power_ack) begin
                  state <= gps_corr_pkg::RELEASE;
               end
            end
            gps_corr_pkg::RELEASE: begin
               if (!i_power_ack) begin
                  state <= gps_corr_pkg::IDLE;
               end
            end
            default: state <= gps_corr_pkg::IDLE;
         endcase
      end
   end

   assign o_power_req    = (state == gps_corr_pkg::HOLD);
   assign o_power_early  = pwr[gps_corr_pkg::TAP_EARLY];
   assign o_power_prompt = pwr[gps_corr_pkg::TAP_PROMPT];
   assign o_power_late   = pwr[gps_corr_pkg::TAP_LATE];

   req_until_ack: assert property (@(posedge clk) disable iff (i_reset)
      o_power_req && !i_power_ack |=> o_power_req)
      else $error("power req dropped before ack");

   powers_held: assert property (@(posedge clk) disable iff (i_reset)
      o_power_req |=> !o_power_req ||
                      $stable({o_power_early, o_power_prompt, o_power_late}))
      else $error("powers changed while req high");

endmodule

//--- src/correlator_bank.sv
`timescale 1ns/1ps
`include "gps_corr_consts.svh"

module correlator_bank (
   input logic        clk,
   input logic        i_reset,
   baseband_if.sink   bb,
   corr_dump_if.source dump
);

   localparam int LINE_LEN = 2 * `CODE_SPACING;
   localparam int CNT_WIDTH = $clog2(`SAMPLES_PER_DUMP);

   logic [LINE_LEN-1:0]  code_line;
   logic [CNT_WIDTH-1:0] sample_cnt;
   logic                 last_sample;
   logic [2:0]           chip;
   gps_corr_pkg::acc_t   prod_i;
   gps_corr_pkg::acc_t   prod_q;
   gps_corr_pkg::acc_t   acc_i [3];
   gps_corr_pkg::acc_t   acc_q [3];

   // Bit 0 holds the chip of the previous valid sample.
   always_ff @(posedge clk) begin
      if (i_reset) begin
         code_line <= '0;
      end else if (bb.valid) begin
         code_line <= {code_line[LINE_LEN-2:0], bb.ca_bit};
      end
   end

   assign chip[gps_corr_pkg::TAP_EARLY]  = bb.ca_bit;
   assign chip[gps_corr_pkg::TAP_PROMPT] = code_line[`CODE_SPACING-1];
   assign chip[gps_corr_pkg::TAP_LATE]   = code_line[LINE_LEN-1];

   assign prod_i = gps_corr_pkg::acc_t'(bb.i);
   assign prod_q = gps_corr_pkg::acc_t'(bb.q);

   // Sample counter and dump strobe.
   assign last_sample = (sample_cnt == CNT_WIDTH'(`SAMPLES_PER_DUMP - 1));

   always_ff @(posedge clk) begin
      if (i_reset) begin
         sample_cnt      <= '0;
         dump.dump_valid <= 1'b0;
      end else begin
         dump.dump_valid <= bb.valid && last_sample;
         if (bb.valid) begin
            sample_cnt <= last_sample ? '0 : sample_cnt + 1'b1;
         end
      end
   end

   // One I/Q pair per tap. A chip of 1 adds, 0 subtracts.
   // During the dump pulse the old sums are shown and the
   // next sample starts from zero.
   for (genvar t = 0; t < 3; t++) begin : g_tap
      gps_corr_pkg::acc_t base_i;
      gps_corr_pkg::acc_t base_q;

      assign base_i = dump.dump_valid ? '0 : acc_i[t];
      assign base_q = dump.dump_valid ? '0 : acc_q[t];

      always_ff @(posedge clk) begin
         if (i_reset) begin
            acc_i[t] <= '0;
            acc_q[t] <= '0;
         end else if (bb.valid) begin
            acc_i[t] <= chip[t] ? base_i + prod_i : base_i - prod_i;
            acc_q[t] <= chip[t] ? base_q + prod_q : base_q - prod_q;
         end else begin
            acc_i[t] <= base_i;
            acc_q[t] <= base_q;
         end
      end
   end

   assign dump.early_i  = acc_i[gps_corr_pkg::TAP_EARLY];
   assign dump.early_q  = acc_q[gps_corr_pkg::TAP_EARLY];
   assign dump.prompt_i = acc_i[gps_corr_pkg::TAP_PROMPT];
   assign dump.prompt_q = acc_q[gps_corr_pkg::TAP_PROMPT];
   assign dump.late_i   = acc_i[gps_corr_pkg::TAP_LATE];
   assign dump.late_q   = acc_q[gps_corr_pkg::TAP_LATE];

   // Dumps are at least a full accumulation apart.
   single_dump: assert property (@(posedge clk) disable iff (i_reset)
      dump.dump_valid |=> !dump.dump_valid)
      else $error("dump_valid high on two consecutive cycles");

endmodule

//--- src/carrier_mixer.sv
`timescale 1ns/1ps
`include "gps_corr_consts.svh"

module carrier_mixer (
   input  logic                   clk,
   input  logic                   i_reset,
   input  logic                   i_sample_valid,
   input  gps_sample_pkg::sample_t i_sample,
   input  logic                   i_ca_bit,
   input  gps_sample_pkg::phase_t  i_doppler_inc,
   baseband_if.source             bb
);

   localparam gps_sample_pkg::carrier_t LVL_HI = `CARRIER_HI;
   localparam gps_sample_pkg::carrier_t LVL_LO = `CARRIER_LO;

   gps_sample_pkg::phase_t   phase;
   logic [2:0]               octant;
   gps_sample_pkg::carrier_t carrier_cos;
   gps_sample_pkg::carrier_t carrier_sin;

   // Phase advances once per valid sample.
   always_ff @(posedge clk) begin
      if (i_reset) begin
         phase <= '0;
      end else if (i_sample_valid) begin
         phase <= phase + i_doppler_inc;
      end
   end

   // The sample uses the phase before its own increment.
   assign octant = phase[`PHASE_WIDTH-1 -: 3];

   always_comb begin
      case (octant)
         3'd0:    begin carrier_cos = LVL_HI;  carrier_sin = LVL_LO;  end
         3'd1:    begin carrier_cos = LVL_LO;  carrier_sin = LVL_HI;  end
         3'd2:    begin carrier_cos = -LVL_LO; carrier_sin = LVL_HI;  end
         3'd3:    begin carrier_cos = -LVL_HI; carrier_sin = LVL_LO;  end
         3'd4:    begin carrier_cos = -LVL_HI; carrier_sin = -LVL_LO; end
         3'd5:    begin carrier_cos = -LVL_LO; carrier_sin = -LVL_HI; end
         3'd6:    begin carrier_cos = LVL_LO;  carrier_sin = -LVL_HI; end
         default: begin carrier_cos = LVL_HI;  carrier_sin = -LVL_LO; end
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         bb.valid <= 1'b0;
      end else begin
         bb.valid <= i_sample_valid;
      end
   end

   // Products and chip travel with the valid pulse.
   always_ff @(posedge clk) begin
      if (i_sample_valid) begin
         bb.i      <= gps_sample_pkg::baseband_t'(i_sample) *
                      gps_sample_pkg::baseband_t'(carrier_cos);
         bb.q      <= gps_sample_pkg::baseband_t'(i_sample) *
                      gps_sample_pkg::baseband_t'(carrier_sin);
         bb.ca_bit <= i_ca_bit;
      end
   end

   // A nonzero sample must never mix down to zero.
   nonzero_carrier: assert property (@(posedge clk) disable iff (i_reset)
      i_sample_valid && i_sample != '0 |=> bb.valid && bb.i != '0 && bb.q != '0)
      else $error("carrier table gave a zero level");

endmodule

//--- src/corr_dump_if.sv
`timescale 1ns/1ps

interface corr_dump_if;

   // One pulse per dump, values stable during it.
   logic               dump_valid;
   gps_corr_pkg::acc_t early_i;
   gps_corr_pkg::acc_t early_q;
   gps_corr_pkg::acc_t prompt_i;
   gps_corr_pkg::acc_t prompt_q;
   gps_corr_pkg::acc_t late_i;
   gps_corr_pkg::acc_t late_q;

   modport source (
      output dump_valid,
      output early_i, output early_q,
      output prompt_i, output prompt_q,
      output late_i, output late_q
   );

   modport sink (
      input dump_valid,
      input early_i, input early_q,
      input prompt_i, input prompt_q,
      input late_i, input late_q
   );

endinterface

//--- src/baseband_if.sv
`timescale 1ns/1ps

interface baseband_if;

   // One pulse per mixed sample, no back-pressure.
   logic                      valid;
   gps_sample_pkg::baseband_t i;
   gps_sample_pkg::baseband_t q;
   // Code chip aligned with i and q.
   logic                      ca_bit;

   modport source (output valid, output i, output q, output ca_bit);

   modport sink (input valid, input i, input q, input ca_bit);

endinterface

//--- src/gps_corr_pkg.sv
`include "gps_corr_consts.svh"

package gps_corr_pkg;

   // Signed I or Q accumulation over one dump.
   typedef logic signed [`ACC_WIDTH-1:0] acc_t;

   // Absolute value of an accumulation.
   typedef logic [`MAG_WIDTH-1:0] mag_t;

   // I squared plus Q squared.
   typedef logic [`POWER_WIDTH-1:0] power_t;

   // Correlator tap select.
   typedef enum logic [1:0] {
      TAP_EARLY  = 2'd0,
      TAP_PROMPT = 2'd1,
      TAP_LATE   = 2'd2
   } tap_e;

   // Power detector FSM.
   typedef enum logic [2:0] {
      IDLE    = 3'd0,
      SQUARE  = 3'd1,
      SUM     = 3'd2,
      HOLD    = 3'd3,
      RELEASE = 3'd4
   } power_state_e;

endpackage

//--- src/gps_sample_pkg.sv
`include "gps_corr_consts.svh"

package gps_sample_pkg;

   // Raw signed input sample from the front end.
   typedef logic signed [`SAMPLE_WIDTH-1:0] sample_t;

   // Carrier level from the octant table, always +-1 or +-2.
   typedef logic signed [`CARRIER_WIDTH-1:0] carrier_t;

   // Sample times carrier.
   typedef logic signed [`BASEBAND_WIDTH-1:0] baseband_t;

   // Carrier phase and Doppler increment.
   typedef logic [`PHASE_WIDTH-1:0] phase_t;

endpackage

//--- include/gps_corr_consts.svh
`ifndef GPS_CORR_CONSTS_SVH
`define GPS_CORR_CONSTS_SVH

// Sample side widths.
`define SAMPLE_WIDTH 4
`define CARRIER_WIDTH 3
`define BASEBAND_WIDTH 6
`define PHASE_WIDTH 16

// Carrier table magnitudes, large and small level.
`define CARRIER_HI 2
`define CARRIER_LO 1

// Accumulate-and-dump length in valid samples.
`define SAMPLES_PER_DUMP 64

// Early to prompt and prompt to late spacing.
`define CODE_SPACING 2

// Correlation side widths.
`define ACC_WIDTH 12
`define MAG_WIDTH 11
`define POWER_WIDTH 23

`endif
